// File: mmu_pkg.sv
`default_nettype none

package mmu_pkg;

    localparam int VPN_W      = 20;
    localparam int PPN_W      = 22;
    localparam int PA_W       = 34;
    localparam int PAGE_OFF_W = 12;
    localparam int VA_W       = VPN_W + PAGE_OFF_W;

    // sv32 page-table entry, bit 0 is v
    typedef struct packed {
        logic [PPN_W-1:0] ppn;
        logic [1:0]       rsw;
        logic             d;
        logic             a;
        logic             g;
        logic             u;
        logic             x;
        logic             w;
        logic             r;
        logic             v;
    } pte_t;

    // walker write into one tlb slot
    typedef struct packed {
        logic [VPN_W-1:0] vpn;
        logic             spage;
        pte_t             pte;
    } tlb_wr_t;

    // combined result of all slots
    typedef struct packed {
        logic             hit;
        logic             spage;
        pte_t             pte;
    } tlb_lookup_t;

    typedef enum logic [1:0] {
        PRV_U = 2'd0,
        PRV_S = 2'd1,
        PRV_M = 2'd3
    } prv_t;

    typedef enum logic [1:0] {
        ACC_R = 2'd0,
        ACC_W = 2'd1,
        ACC_X = 2'd2
    } access_t;

    typedef enum logic [1:0] {
        ERR_NONE   = 2'd0,
        ERR_PAGE   = 2'd1,
        ERR_ACCESS = 2'd2
    } xlat_err_t;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_CHECK = 2'd1,
        ST_MREQ  = 2'd2,
        ST_PTE   = 2'd3
    } walk_state_t;

endpackage

`default_nettype wire

// File: tlb_entry.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_entry
    import mmu_pkg::*;
(
    input  logic            clk,
    input  logic            rstn,
    input  logic            wr_en,
    input  tlb_wr_t         wr,
    input  logic [VPN_W-1:0] vpn,
    input  logic            flush_req,
    input  logic            flush_all,
    input  logic [VA_W-1:0] flush_vaddr,
    output logic            hit,
    output logic            spage,
    output pte_t            pte
);

    logic             valid;
    logic [VPN_W-1:0] tag;
    logic             spage_q;
    pte_t             pte_q;
    logic             flush_hit;

    // megapage slots ignore vpn0
    function automatic logic vpn_match(logic [VPN_W-1:0] a, logic [VPN_W-1:0] t, logic sp);
        return (a[VPN_W-1:VPN_W/2] == t[VPN_W-1:VPN_W/2]) &&
               (sp || a[VPN_W/2-1:0] == t[VPN_W/2-1:0]);
    endfunction

    assign hit   = valid && vpn_match(vpn, tag, spage_q);
    assign spage = spage_q;
    assign pte   = pte_q;

    assign flush_hit = flush_req &&
                       (flush_all || vpn_match(flush_vaddr[PAGE_OFF_W +: VPN_W], tag, spage_q));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= 1'b0;
        end else if (flush_hit) begin
            valid <= 1'b0;
        end else if (wr_en) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag     <= wr.vpn;
            spage_q <= wr.spage;
            pte_q   <= wr.pte;
        end
    end

endmodule

`default_nettype wire

// File: tlb_fill.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_fill #(
    parameter int TLB_ENTRIES = 4
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   tlb_we,
    input  logic                   flush_req,
    input  logic                   flush_all,
    output logic [TLB_ENTRIES-1:0] wr_en
);

    localparam int PTR_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

    logic [PTR_W-1:0] ptr;
    logic             fill;

    // a flush in the same cycle wins over the write
    assign fill = tlb_we && !flush_req;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ptr <= '0;
        end else if (flush_req && flush_all) begin
            ptr <= '0;
        end else if (fill) begin
            if (ptr == PTR_W'(TLB_ENTRIES - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

    // victim decode
    assign wr_en = fill ? (TLB_ENTRIES'(1) << ptr) : '0;

    // one walk ends in at most one fill
    a_wr_pulse: assert property (
        @(posedge clk) disable iff (!rstn)
        tlb_we |=> !tlb_we
    ) else $error("tlb_fill: write strobe held for two cycles");

endmodule

`default_nettype wire

// File: tlb_match.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_match
    import mmu_pkg::*;
#(
    parameter int TLB_ENTRIES = 4
) (
    input  logic [TLB_ENTRIES-1:0] hit_vec,
    input  logic [TLB_ENTRIES-1:0] spage_vec,
    input  pte_t [TLB_ENTRIES-1:0] pte_vec,
    output tlb_lookup_t            lookup
);

    logic                     sel_spage;
    logic [$bits(pte_t)-1:0]  sel_pte;

    // and-or mux, at most one hit line is expected
    always_comb begin
        sel_spage = 1'b0;
        sel_pte   = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            sel_spage = sel_spage | (hit_vec[i] & spage_vec[i]);
            sel_pte   = sel_pte | (pte_vec[i] & {$bits(pte_t){hit_vec[i]}});
        end
    end

    always_comb begin
        lookup.hit   = |hit_vec;
        lookup.spage = sel_spage;
        lookup.pte   = pte_t'(sel_pte);
    end

    // two slots on one page would merge their ptes in the mux
    a_single_hit: assert final ($onehot0(hit_vec))
        else $error("tlb_match: multiple slots hit");

endmodule

`default_nettype wire

// File: mmu.sv
`timescale 1ns/1ns
`default_nettype none

module mmu
    import mmu_pkg::*;
(
    input  logic             clk,
    input  logic             rstn,

    input  logic             va_valid,
    input  logic [VA_W-1:0]  va,
    input  access_t          access,
    input  prv_t             prv,
    input  logic             sum,
    input  logic             mprv,
    input  prv_t             mpp,
    input  logic             satp_mode,
    input  logic [PPN_W-1:0] satp_ppn,

    input  logic             pmp_v,
    input  logic             pmp_l,
    input  logic             pmp_r,
    input  logic             pmp_w,
    input  logic             pmp_x,

    input  tlb_lookup_t      lookup,
    output logic [VPN_W-1:0] tlb_vpn,
    output logic             tlb_we,
    output tlb_wr_t          tlb_wr,

    output logic             m_arvalid,
    output logic [PA_W-1:0]  m_araddr,
    input  logic             m_arready,
    input  logic             m_rvalid,
    input  logic [31:0]      m_rdata,
    input  logic [1:0]       m_rresp,
    input  logic             m_rlast,
    output logic             m_rready,

    output logic             busy,
    output logic             pa_valid,
    output logic [PA_W-1:0]  pa,
    output xlat_err_t        pa_bad
);

    walk_state_t      state;
    walk_state_t      nxt_state;
    logic             accept;
    logic             xlat_en;
    prv_t             prv_eff;
    prv_t             prv_q;
    prv_t             chk_prv;
    access_t          acc_q;
    access_t          chk_acc;
    logic             sum_q;
    logic [VA_W-1:0]  va_q;
    logic [PPN_W-1:0] ppn_q;
    logic             level_q;
    pte_t             pte_q;
    logic             rerr_q;
    logic             ar_done;
    logic             rd_done;
    logic             pte_leaf;
    logic             pte_bad;
    logic             leaf_pf;
    logic             hit_pf;
    logic             pmp_err;
    logic             descend;
    logic             done;
    logic [PA_W-1:0]  res_pa;
    xlat_err_t        res_err;

    function automatic logic page_fault(pte_t p, prv_t pv, access_t a, logic s);
        return (a == ACC_R && !p.r) ||
               (a == ACC_W && !p.w) ||
               (a == ACC_X && !p.x) ||
               (pv == PRV_U && !p.u) ||
               (pv == PRV_S && p.u && (!s || a == ACC_X)) ||
               !p.a ||
               (a == ACC_W && !p.d);
    endfunction

    // megapage keeps vpn0 from the virtual address
    function automatic logic [PA_W-1:0] form_pa(pte_t p, logic sp, logic [VA_W-1:0] v);
        logic [PPN_W-1:0] ppn;
        ppn = p.ppn;
        if (sp) begin
            ppn[VPN_W/2-1:0] = v[PAGE_OFF_W +: VPN_W/2];
        end
        return {ppn, v[PAGE_OFF_W-1:0]};
    endfunction

    function automatic xlat_err_t err_code(logic pf, logic af);
        return pf ? ERR_PAGE : (af ? ERR_ACCESS : ERR_NONE);
    endfunction

    // mprv applies to loads and stores only
    assign prv_eff = (access != ACC_X && mprv) ? mpp : prv;
    assign xlat_en = satp_mode && prv_eff != PRV_M;
    assign accept  = va_valid && !busy;

    assign chk_prv = (state == ST_IDLE) ? prv_eff : prv_q;
    assign chk_acc = (state == ST_IDLE) ? access : acc_q;
    assign pmp_err = (!pmp_v && chk_prv != PRV_M) ||
                     ((pmp_l || chk_prv != PRV_M) &&
                      ((chk_acc == ACC_R && !pmp_r) ||
                       (chk_acc == ACC_W && !pmp_w) ||
                       (chk_acc == ACC_X && !pmp_x)));

    assign pte_leaf = pte_q.r || pte_q.x;
    assign pte_bad  = !pte_q.v || (!pte_q.r && pte_q.w);
    assign leaf_pf  = page_fault(pte_q, prv_q, acc_q, sum_q) ||
                      (level_q && |pte_q.ppn[VPN_W/2-1:0]);
    assign hit_pf   = page_fault(lookup.pte, prv_q, acc_q, sum_q);

    assign tlb_vpn   = va_q[PAGE_OFF_W +: VPN_W];
    assign tlb_wr    = '{vpn: va_q[PAGE_OFF_W +: VPN_W], spage: level_q, pte: pte_q};
    assign m_arvalid = (state == ST_MREQ) && !ar_done;
    assign m_araddr  = {ppn_q, level_q ? va_q[VA_W-1 -: VPN_W/2] : va_q[PAGE_OFF_W +: VPN_W/2],
                        2'b00};
    assign m_rready  = 1'b1;
    assign rd_done   = (state == ST_MREQ) && m_rvalid && m_rlast;

    always_comb begin
        nxt_state = state;
        done      = 1'b0;
        descend   = 1'b0;
        tlb_we    = 1'b0;
        res_pa    = form_pa(pte_q, level_q, va_q);
        res_err   = ERR_NONE;
        case (state)
            ST_IDLE: begin
                res_pa  = {{(PA_W-VA_W){1'b0}}, va};
                res_err = err_code(1'b0, pmp_err);
                if (accept && xlat_en) begin
                    nxt_state = ST_CHECK;
                end else if (accept) begin
                    done = 1'b1;
                end
            end
            ST_CHECK: begin
                res_pa  = form_pa(lookup.pte, lookup.spage, va_q);
                res_err = err_code(hit_pf, pmp_err);
                if (lookup.hit) begin
                    done      = 1'b1;
                    nxt_state = ST_IDLE;
                end else begin
                    nxt_state = ST_MREQ;
                end
            end
            ST_MREQ: begin
                if (rd_done) begin
                    nxt_state = ST_PTE;
                end
            end
            ST_PTE: begin
                nxt_state = ST_IDLE;
                done      = 1'b1;
                if (rerr_q) begin
                    res_err = ERR_ACCESS;
                end else if (pte_bad || (!pte_leaf && !level_q)) begin
                    res_err = ERR_PAGE;
                end else if (!pte_leaf) begin
                    // pointer to the level-0 table
                    done      = 1'b0;
                    descend   = 1'b1;
                    nxt_state = ST_MREQ;
                end else begin
                    res_err = err_code(leaf_pf, pmp_err);
                    tlb_we  = !leaf_pf;
                end
            end
            default: nxt_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= ST_IDLE;
            busy     <= 1'b0;
            pa_valid <= 1'b0;
            ar_done  <= 1'b0;
        end else begin
            state    <= nxt_state;
            pa_valid <= done;
            if (accept) begin
                busy <= 1'b1;
            end else if (pa_valid) begin
                busy <= 1'b0;
            end
            if (rd_done) begin
                ar_done <= 1'b0;
            end else if (m_arvalid && m_arready) begin
                ar_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            va_q  <= va;
            acc_q <= access;
            prv_q <= prv_eff;
            sum_q <= sum;
        end
        if (accept) begin
            ppn_q   <= satp_ppn;
            level_q <= 1'b1;
        end else if (descend) begin
            ppn_q   <= pte_q.ppn;
            level_q <= 1'b0;
        end
        if (rd_done) begin
            pte_q  <= pte_t'(m_rdata);
            rerr_q <= (m_rresp != 2'b00);
        end
        if (done) begin
            pa     <= res_pa;
            pa_bad <= res_err;
        end
    end

    a_no_req_busy: assert property (
        @(posedge clk) disable iff (!rstn)
        va_valid |-> !busy
    ) else $error("mmu: va_valid while busy");

    // a walk only starts on a miss, so its fill never aliases a live slot
    a_fill_on_miss: assert property (
        @(posedge clk) disable iff (!rstn)
        tlb_we |-> !lookup.hit
    ) else $error("mmu: tlb write for a page that already hits");

endmodule

`default_nettype wire

// File: mmu_top.sv
`timescale 1ns/1ns
`default_nettype none

module mmu_top
    import mmu_pkg::*;
#(
    parameter int TLB_ENTRIES = 4
) (
    input  logic             clk,
    input  logic             rstn,

    input  logic             va_valid,
    input  logic [VA_W-1:0]  va,
    input  access_t          access,
    input  prv_t             prv,
    input  logic             sum,
    input  logic             mprv,
    input  prv_t             mpp,
    input  logic             satp_mode,
    input  logic [PPN_W-1:0] satp_ppn,

    input  logic             pmp_v,
    input  logic             pmp_l,
    input  logic             pmp_r,
    input  logic             pmp_w,
    input  logic             pmp_x,

    input  logic             flush_req,
    input  logic             flush_all,
    input  logic [VA_W-1:0]  flush_vaddr,

    output logic             m_arvalid,
    output logic [PA_W-1:0]  m_araddr,
    input  logic             m_arready,
    input  logic             m_rvalid,
    input  logic [31:0]      m_rdata,
    input  logic [1:0]       m_rresp,
    input  logic             m_rlast,
    output logic             m_rready,

    output logic             busy,
    output logic             pa_valid,
    output logic [PA_W-1:0]  pa,
    output xlat_err_t        pa_bad
);

    logic [VPN_W-1:0]       tlb_vpn;
    logic                   tlb_we;
    tlb_wr_t                tlb_wr;
    tlb_lookup_t            lookup;
    logic [TLB_ENTRIES-1:0] wr_en;
    logic [TLB_ENTRIES-1:0] hit_vec;
    logic [TLB_ENTRIES-1:0] spage_vec;
    pte_t [TLB_ENTRIES-1:0] pte_vec;

    mmu u_mmu (
        .clk       (clk),
        .rstn      (rstn),
        .va_valid  (va_valid),
        .va        (va),
        .access    (access),
        .prv       (prv),
        .sum       (sum),
        .mprv      (mprv),
        .mpp       (mpp),
        .satp_mode (satp_mode),
        .satp_ppn  (satp_ppn),
        .pmp_v     (pmp_v),
        .pmp_l     (pmp_l),
        .pmp_r     (pmp_r),
        .pmp_w     (pmp_w),
        .pmp_x     (pmp_x),
        .lookup    (lookup),
        .tlb_vpn   (tlb_vpn),
        .tlb_we    (tlb_we),
        .tlb_wr    (tlb_wr),
        .m_arvalid (m_arvalid),
        .m_araddr  (m_araddr),
        .m_arready (m_arready),
        .m_rvalid  (m_rvalid),
        .m_rdata   (m_rdata),
        .m_rresp   (m_rresp),
        .m_rlast   (m_rlast),
        .m_rready  (m_rready),
        .busy      (busy),
        .pa_valid  (pa_valid),
        .pa        (pa),
        .pa_bad    (pa_bad)
    );

    tlb_fill #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_tlb_fill (
        .clk       (clk),
        .rstn      (rstn),
        .tlb_we    (tlb_we),
        .flush_req (flush_req),
        .flush_all (flush_all),
        .wr_en     (wr_en)
    );

    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_entry
        tlb_entry u_tlb_entry (
            .clk         (clk),
            .rstn        (rstn),
            .wr_en       (wr_en[i]),
            .wr          (tlb_wr),
            .vpn         (tlb_vpn),
            .flush_req   (flush_req),
            .flush_all   (flush_all),
            .flush_vaddr (flush_vaddr),
            .hit         (hit_vec[i]),
            .spage       (spage_vec[i]),
            .pte         (pte_vec[i])
        );
    end

    tlb_match #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_tlb_match (
        .hit_vec   (hit_vec),
        .spage_vec (spage_vec),
        .pte_vec   (pte_vec),
        .lookup    (lookup)
    );

endmodule

`default_nettype wire

// File: tb_axi_mem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_axi_mem (
    input  logic        clk,
    input  logic        rstn,
    input  logic        arvalid,
    input  logic [33:0] araddr,
    output logic        arready,
    output logic        rvalid,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast,
    input  logic        rready
);

    localparam logic [33:0] ERR_ADDR = 34'h0_3FFF_FFFC;

    // keyed by word address {ppn, index}
    logic [31:0] mem [logic [31:0]];
    logic        pending;
    logic        wait_q;

    function automatic logic [31:0] pte(logic [21:0] ppn, logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    task automatic put(logic [21:0] ppn, logic [9:0] idx, logic [31:0] data);
        mem[{ppn, idx}] = data;
    endtask

    // flags are d a g u x w r v
    initial begin
        put(22'h10, 10'd1, pte(22'h11, 8'h01));
        put(22'h10, 10'd2, pte(22'h400, 8'hcf));
        // misaligned megapage
        put(22'h10, 10'd3, pte(22'h401, 8'hcf));
        put(22'h10, 10'd4, pte(22'h12, 8'h01));
        put(22'h10, 10'd5, pte(22'h3ffff, 8'h01));
        for (int i = 0; i < 5; i++) begin
            put(22'h11, 10'(i), pte(22'h100 + 22'(i), 8'hcf));
        end
        put(22'h11, 10'd5, pte(22'h105, 8'hcb));
        put(22'h11, 10'd6, pte(22'h106, 8'h4f));
        put(22'h11, 10'd7, pte(22'h107, 8'h8f));
        put(22'h12, 10'd0, pte(22'h200, 8'hdf));
    end

    // arready comes one cycle late
    assign arready = wait_q && !pending;
    assign rlast   = rvalid;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pending <= 1'b0;
            wait_q  <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= '0;
        end else begin
            wait_q <= arvalid && !pending && !arready;
            // read data is held until the master takes it
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                pending <= 1'b0;
            end
            if (arvalid && arready) begin
                pending <= 1'b1;
                rvalid  <= 1'b1;
                rresp   <= (araddr == ERR_ADDR) ? 2'b10 : 2'b00;
                rdata   <= mem.exists(araddr[33:2]) ? mem[araddr[33:2]] : 32'h0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_mmu_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mmu_top
    import mmu_pkg::*;
();

    localparam logic [21:0] SATP_PPN = 22'h10;

    typedef struct {
        string       name;
        logic [9:0]  vpn1;
        logic [9:0]  vpn0;
        access_t     acc;
        prv_t        prv;
        logic        mprv;
        logic        sum;
        logic        mode;
        logic [2:0]  pmp;
        int          flush;
        logic [21:0] exp_ppn;
        xlat_err_t   exp_err;
        int          exp_reads;
        logic [21:0] l0_ppn;
        int          exp_lat;
    } vec_t;

    logic clk, rstn, va_valid, sum, mprv, satp_mode;
    logic [31:0] va, flush_vaddr;
    access_t access;
    prv_t prv, mpp;
    logic [21:0] satp_ppn;
    logic pmp_v, pmp_l, pmp_r, pmp_w, pmp_x, flush_req, flush_all;
    logic m_arvalid, m_arready, m_rvalid, m_rlast, m_rready, busy, pa_valid;
    logic [33:0] m_araddr, pa;
    logic [31:0] m_rdata;
    logic [1:0] m_rresp;
    xlat_err_t pa_bad;

    vec_t        tbl[$];
    logic [33:0] ar_q[$];
    logic [15:0] lfsr;
    int          errors;
    int          failed_tests;
    logic        timed_out;

    mmu_top #(.TLB_ENTRIES(4)) u_mmu_top (.*);

    tb_axi_mem u_mem (
        .clk(clk), .rstn(rstn), .arvalid(m_arvalid), .araddr(m_araddr),
        .arready(m_arready), .rvalid(m_rvalid), .rdata(m_rdata), .rresp(m_rresp),
        .rlast(m_rlast), .rready(m_rready)
    );

    always #20 clk = ~clk;

    // count AR handshakes away from the active edge
    always @(negedge clk) begin
        if (rstn && m_arvalid && m_arready) begin
            ar_q.push_back(m_araddr);
        end
    end

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [11:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[10:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic compare_val(string name, string what, logic [33:0] exp, logic [33:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s %s expected %h actual %h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic add(string n, logic [9:0] v1, logic [9:0] v0, access_t a, prv_t p,
                       logic mp, logic s, logic md, logic [2:0] pm, int fl,
                       logic [21:0] ppn, xlat_err_t e, int rd, logic [21:0] l0, int lat);
        tbl.push_back('{n, v1, v0, a, p, mp, s, md, pm, fl, ppn, e, rd, l0, lat});
    endtask

    task automatic run_test(vec_t t);
        logic [11:0] off;
        logic [31:0] va_w;
        int          cyc;
        logic        got;
        logic        busy_held;
        int          err_start;
        take_bits(12, off);
        va_w      = {t.vpn1, t.vpn0, off};
        err_start = errors;
        @(posedge clk);
        #5;
        compare_val(t.name, "busy_idle", 34'(0), 34'(busy));
        if (t.flush != 0) begin
            flush_req   = 1'b1;
            flush_all   = (t.flush == 1);
            flush_vaddr = va_w;
            @(posedge clk);
            #5;
            flush_req = 1'b0;
            flush_all = 1'b0;
        end
        ar_q.delete();
        va = va_w;
        access = t.acc;
        prv = t.prv;
        mprv = t.mprv;
        sum = t.sum;
        satp_mode = t.mode;
        {pmp_r, pmp_w, pmp_x} = t.pmp;
        va_valid = 1'b1;
        cyc = 0;
        got = 1'b0;
        busy_held = 1'b1;
        while (!got && cyc < 200) begin
            @(posedge clk);
            #1;
            cyc++;
            got = pa_valid;
            // busy covers every cycle up to and including pa_valid
            if (busy !== 1'b1) begin
                busy_held = 1'b0;
            end
            #4;
            va_valid = 1'b0;
        end
        if (!got) begin
            $display("timeout: test %s saw no pa_valid within 200 cycles", t.name);
            errors++;
            failed_tests++;
            timed_out = 1'b1;
        end else begin
            compare_val(t.name, "busy", 34'(1), 34'(busy_held));
            compare_val(t.name, "pa_bad", 34'(t.exp_err), 34'(pa_bad));
            if (t.exp_err == ERR_NONE) begin
                compare_val(t.name, "pa", {t.exp_ppn, off}, pa);
            end
            compare_val(t.name, "reads", 34'(t.exp_reads), 34'(ar_q.size()));
            if (t.exp_reads >= 1 && ar_q.size() >= 1) begin
                compare_val(t.name, "araddr0", {SATP_PPN, t.vpn1, 2'b00}, ar_q[0]);
            end
            if (t.exp_reads == 2 && ar_q.size() == 2) begin
                compare_val(t.name, "araddr1", {t.l0_ppn, t.vpn0, 2'b00}, ar_q[1]);
            end
            if (t.exp_lat != 0) begin
                compare_val(t.name, "latency", 34'(t.exp_lat), 34'(cyc));
            end
            if (errors == err_start) begin
                $display("test %s ok", t.name);
            end else begin
                $display("test %s failed", t.name);
                failed_tests++;
            end
        end
    endtask

    initial begin
        clk = 0;
        rstn = 0;
        va_valid = 0;
        va = '0;
        access = ACC_R;
        prv = PRV_S;
        sum = 0;
        mprv = 0;
        mpp = PRV_U;
        satp_mode = 0;
        satp_ppn = SATP_PPN;
        pmp_v = 1;
        pmp_l = 0;
        pmp_r = 1;
        pmp_w = 1;
        pmp_x = 1;
        flush_req = 0;
        flush_all = 0;
        flush_vaddr = '0;
        lfsr = 16'd95;
        errors = 0;
        failed_tests = 0;
        timed_out = 1'b0;
        add("bare", 10'h048, 10'h345, ACC_R, PRV_S, 0, 0, 0, 3'b111, 0,
            22'h012345, ERR_NONE, 0, 0, 1);
        add("m_mode", 10'h001, 10'h001, ACC_W, PRV_M, 0, 0, 1, 3'b111, 0,
            22'h401, ERR_NONE, 0, 0, 1);
        add("walk4k", 10'h001, 10'h000, ACC_R, PRV_S, 0, 0, 1, 3'b111, 0,
            22'h100, ERR_NONE, 2, 22'h11, 0);
        add("hit4k", 10'h001, 10'h000, ACC_R, PRV_S, 0, 0, 1, 3'b111, 0,
            22'h100, ERR_NONE, 0, 0, 2);
        add("mega", 10'h002, 10'h155, ACC_R, PRV_S, 0, 0, 1, 3'b111, 0,
            {12'h001, 10'h155}, ERR_NONE, 1, 0, 0);
        add("mega_misal", 10'h003, 10'h000, ACC_R, PRV_S, 0, 0, 1, 3'b111, 0,
            0, ERR_PAGE, 1, 0, 0);
        add("flush_all", 10'h001, 10'h000, ACC_R, PRV_S, 0, 0, 1, 3'b111, 1,
            22'h100, ERR_NONE, 2, 22'h11, 0);
        add("flush_page", 10'h001, 10'h000, ACC_R, PRV_S, 0, 0, 1, 3'b111, 2,
            22'h100, ERR_NONE, 2, 22'h11, 0);
        add("fill1", 10'h001, 10'h001, ACC_R, PRV_S, 0, 0, 1, 3'b111, 0,
            22'h101, ERR_NONE, 2, 22'h11, 0);
        add("fill2", 10'h001, 10'h002, ACC_R, PRV_S, 0, 0, 1, 3'b111, 0,
            22'h102, ERR_NONE, 2, 22'h11, 0);
        add("fill3", 10'h001, 10'h003, ACC_R, PRV_S, 0, 0, 1, 3'b111, 0,
            22'h103, ERR_NONE, 2, 22'h11, 0);
        add("fill4", 10'h001, 10'h004, ACC_R, PRV_S, 0, 0, 1, 3'b111, 0,
            22'h104, ERR_NONE, 2, 22'h11, 0);
        add("evicted", 10'h001, 10'h000, ACC_R, PRV_S, 0, 0, 1, 3'b111, 0,
            22'h100, ERR_NONE, 2, 22'h11, 0);
        add("recent", 10'h001, 10'h004, ACC_R, PRV_S, 0, 0, 1, 3'b111, 0,
            22'h104, ERR_NONE, 0, 0, 2);
        add("no_w", 10'h001, 10'h005, ACC_W, PRV_S, 0, 0, 1, 3'b111, 0,
            0, ERR_PAGE, 2, 22'h11, 0);
        add("no_d", 10'h001, 10'h006, ACC_W, PRV_S, 0, 0, 1, 3'b111, 0,
            0, ERR_PAGE, 2, 22'h11, 0);
        add("no_a", 10'h001, 10'h007, ACC_R, PRV_S, 0, 0, 1, 3'b111, 0,
            0, ERR_PAGE, 2, 22'h11, 0);
        add("u_on_s", 10'h001, 10'h004, ACC_R, PRV_U, 0, 0, 1, 3'b111, 0,
            0, ERR_PAGE, 0, 0, 0);
        add("s_on_u", 10'h004, 10'h000, ACC_R, PRV_S, 0, 0, 1, 3'b111, 0,
            0, ERR_PAGE, 2, 22'h12, 0);
        add("s_exec_u", 10'h004, 10'h000, ACC_X, PRV_S, 0, 1, 1, 3'b111, 0,
            0, ERR_PAGE, 2, 22'h12, 0);
        add("s_sum_u", 10'h004, 10'h000, ACC_R, PRV_S, 0, 1, 1, 3'b111, 0,
            22'h200, ERR_NONE, 2, 22'h12, 0);
        add("mprv_u", 10'h001, 10'h000, ACC_R, PRV_M, 1, 0, 1, 3'b111, 0,
            0, ERR_PAGE, 0, 0, 0);
        add("pmp_deny", 10'h001, 10'h004, ACC_R, PRV_S, 0, 0, 1, 3'b011, 0,
            0, ERR_ACCESS, 0, 0, 0);
        add("pmp_and_pf", 10'h001, 10'h005, ACC_W, PRV_S, 0, 0, 1, 3'b101, 0,
            0, ERR_PAGE, 2, 22'h11, 0);
        add("slverr", 10'h005, 10'h3ff, ACC_R, PRV_S, 0, 0, 1, 3'b111, 0,
            0, ERR_ACCESS, 2, 22'h3ffff, 0);
        repeat (3) @(posedge clk);
        #5;
        rstn = 1;
        for (int i = 0; i < tbl.size() && !timed_out; i++) begin
            run_test(tbl[i]);
        end
        $display("tests %0d, failed %0d, errors %0d", tbl.size(), failed_tests, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mmu_top.f
mmu_pkg.sv
tlb_entry.sv
tlb_fill.sv
tlb_match.sv
mmu.sv
mmu_top.sv
tb_axi_mem.sv
tb_mmu_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv \
    -f mmu_top.f --top-module tb_mmu_top -o sim_mmu_top

./obj_dir/sim_mmu_top > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    exit 1
fi
exit 0
